/* barrel_pkg.sv */
package barrel_pkg;

  // Thread and datapath sizes
  localparam int num_harts  = 4;
  localparam int hart_w     = $clog2(num_harts);
  localparam int xlen       = 32;
  localparam int reg_addr_w = 5;
  localparam int shamt_w    = $clog2(xlen);  // Shift amount taken from operand low bits

  // Major opcodes accepted by the core
  localparam logic [6:0] opc_op     = 7'b0110011;  // Register-register ALU
  localparam logic [6:0] opc_op_imm = 7'b0010011;  // Register-immediate ALU

  // funct3 field values for the supported operations
  localparam logic [2:0] f3_add = 3'b000;  // ADD, SUB, ADDI
  localparam logic [2:0] f3_sll = 3'b001;  // SLL, SLLI
  localparam logic [2:0] f3_slt = 3'b010;  // SLT, SLTI
  localparam logic [2:0] f3_xor = 3'b100;  // XOR, XORI
  localparam logic [2:0] f3_srl = 3'b101;  // SRL, SRLI
  localparam logic [2:0] f3_or  = 3'b110;  // OR, ORI
  localparam logic [2:0] f3_and = 3'b111;  // AND, ANDI

  // funct7 field values
  localparam logic [6:0] funct7_base = 7'b0000000;
  localparam logic [6:0] funct7_alt  = 7'b0100000;  // Selects SUB

  // Operations carried from decode to execute
  typedef enum logic [3:0] {
    alu_add = 4'd0,
    alu_sub = 4'd1,
    alu_sll = 4'd2,
    alu_slt = 4'd3,
    alu_xor = 4'd4,
    alu_srl = 4'd5,
    alu_or  = 4'd6,
    alu_and = 4'd7
  } alu_op_t;

  // One instruction word, seen either as R-type or as I-type
  typedef union packed {
    struct packed {
      logic [6:0]            funct7;
      logic [reg_addr_w-1:0] rs2;
      logic [reg_addr_w-1:0] rs1;
      logic [2:0]            funct3;
      logic [reg_addr_w-1:0] rd;
      logic [6:0]            opcode;
    } r;
    struct packed {
      logic [11:0]           imm12;  // Upper 7 bits double as funct7 for shifts
      logic [reg_addr_w-1:0] rs1;
      logic [2:0]            funct3;
      logic [reg_addr_w-1:0] rd;
      logic [6:0]            opcode;
    } i;
  } rv32_instr_u;

endpackage

/* flist.f */
barrel_pkg.sv
rv32_regfile.sv
rv32_barrel_regfiles.sv
rv32_hart_decoder.sv
rv32_alu_stage.sv
rv32_barrel_top.sv
tb_clock_gen.sv
tb_barrel_top.sv

/* rv32_alu_stage.sv */
module rv32_alu_stage (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             dec_valid,
  output logic                             dec_ready,
  input  logic [barrel_pkg::hart_w-1:0]     dec_hart,
  input  barrel_pkg::alu_op_t               dec_op,
  input  logic                             dec_use_imm,
  input  logic [barrel_pkg::xlen-1:0]       dec_imm,
  input  logic [barrel_pkg::reg_addr_w-1:0] dec_rd,
  input  logic                             dec_illegal,
  input  logic [barrel_pkg::xlen-1:0]       rd1,
  input  logic [barrel_pkg::xlen-1:0]       rd2,
  output logic                             out_valid,
  input  logic                             out_ready,
  output logic [barrel_pkg::hart_w-1:0]     out_hart,
  output logic [barrel_pkg::reg_addr_w-1:0] out_rd,
  output logic [barrel_pkg::xlen-1:0]       out_data,
  output logic                             out_illegal,
  output logic                             wb_en,
  output logic [barrel_pkg::hart_w-1:0]     wb_hart,
  output logic [barrel_pkg::reg_addr_w-1:0] wb_addr,
  output logic [barrel_pkg::xlen-1:0]       wb_data
);

  import barrel_pkg::*;

  logic               load;
  logic               out_fire;
  logic [xlen-1:0]    op_b;
  logic [shamt_w-1:0] shamt;
  logic [xlen-1:0]    alu_res;

  // Accept a new instruction when empty or when the result leaves now
  assign dec_ready = !out_valid || out_ready;
  assign load      = dec_valid && dec_ready;
  assign out_fire  = out_valid && out_ready;

  assign op_b  = dec_use_imm ? dec_imm : rd2;
  assign shamt = op_b[shamt_w-1:0];

  always_comb begin
    case (dec_op)
      alu_add: alu_res = rd1 + op_b;
      alu_sub: alu_res = rd1 - op_b;
      alu_sll: alu_res = rd1 << shamt;
      alu_slt: alu_res = {{(xlen-1){1'b0}}, ($signed(rd1) < $signed(op_b))};
      alu_xor: alu_res = rd1 ^ op_b;
      alu_srl: alu_res = rd1 >> shamt;  // Logical only
      alu_or:  alu_res = rd1 | op_b;
      alu_and: alu_res = rd1 & op_b;
      default: alu_res = '0;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else if (load) begin
      out_valid <= 1'b1;
    end else if (out_ready) begin
      out_valid <= 1'b0;  // Result taken, nothing behind it
    end
  end

  // Result register
  always_ff @(posedge clk) begin
    if (load) begin
      out_hart    <= dec_hart;
      out_rd      <= dec_rd;
      out_data    <= dec_illegal ? '0 : alu_res;
      out_illegal <= dec_illegal;
    end
  end

  // Write-back fires once, on the output handshake
  assign wb_en   = out_fire && !out_illegal && (out_rd != '0);
  assign wb_hart = out_hart;
  assign wb_addr = out_rd;
  assign wb_data = out_data;

endmodule

/* rv32_barrel_regfiles.sv */
module rv32_barrel_regfiles (
  input  logic                             clk,
  input  logic [barrel_pkg::hart_w-1:0]     rsa_hart,  // Hart whose operands are read
  input  logic [barrel_pkg::reg_addr_w-1:0] ra1,
  input  logic [barrel_pkg::reg_addr_w-1:0] ra2,
  output logic [barrel_pkg::xlen-1:0]       rd1,
  output logic [barrel_pkg::xlen-1:0]       rd2,
  input  logic [barrel_pkg::hart_w-1:0]     rd_hart,   // Hart being written back
  input  logic                             wen,
  input  logic [barrel_pkg::reg_addr_w-1:0] wa,
  input  logic [barrel_pkg::xlen-1:0]       wd
);

  import barrel_pkg::*;

  // Per-bank read side
  logic [reg_addr_w-1:0] ra1_bank [num_harts];
  logic [reg_addr_w-1:0] ra2_bank [num_harts];
  logic [xlen-1:0]       rd1_bank [num_harts];
  logic [xlen-1:0]       rd2_bank [num_harts];

  // Per-bank write side, data is common
  logic [reg_addr_w-1:0] wa_bank  [num_harts];
  logic                  wen_bank [num_harts];

  for (genvar h = 0; h < num_harts; h++) begin : g_bank
    // Idle banks see address 0
    assign ra1_bank[h] = (rsa_hart == hart_w'(h)) ? ra1 : '0;
    assign ra2_bank[h] = (rsa_hart == hart_w'(h)) ? ra2 : '0;

    // Only the owning hart's bank may be written
    assign wa_bank[h]  = (rd_hart == hart_w'(h)) ? wa  : '0;
    assign wen_bank[h] = (rd_hart == hart_w'(h)) ? wen : 1'b0;

    rv32_regfile u_regfile (
      .clk (clk),
      .ra1 (ra1_bank[h]),
      .ra2 (ra2_bank[h]),
      .rd1 (rd1_bank[h]),
      .rd2 (rd2_bank[h]),
      .wen (wen_bank[h]),
      .wa  (wa_bank[h]),
      .wd  (wd)
    );
  end

  // Read mux back to the single operand pair
  assign rd1 = rd1_bank[rsa_hart];
  assign rd2 = rd2_bank[rsa_hart];

endmodule

/* rv32_barrel_top.sv */
module rv32_barrel_top (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             in_valid,
  input  logic [barrel_pkg::xlen-1:0]       in_instr,
  output logic                             in_ready,
  output logic [barrel_pkg::hart_w-1:0]     slot_hart,
  output logic                             out_valid,
  input  logic                             out_ready,
  output logic [barrel_pkg::hart_w-1:0]     out_hart,
  output logic [barrel_pkg::reg_addr_w-1:0] out_rd,
  output logic [barrel_pkg::xlen-1:0]       out_data,
  output logic                             out_illegal
);

  import barrel_pkg::*;

  // Decode to execute
  logic                  dec_valid;
  logic                  dec_ready;
  logic [hart_w-1:0]     dec_hart;
  logic [reg_addr_w-1:0] dec_rs1;
  logic [reg_addr_w-1:0] dec_rs2;
  logic [reg_addr_w-1:0] dec_rd;
  alu_op_t               dec_op;
  logic                  dec_use_imm;
  logic [xlen-1:0]       dec_imm;
  logic                  dec_illegal;

  // Operands from the selected bank
  logic [xlen-1:0]       rd1;
  logic [xlen-1:0]       rd2;

  // Write-back path
  logic                  wb_en;
  logic [hart_w-1:0]     wb_hart;
  logic [reg_addr_w-1:0] wb_addr;
  logic [xlen-1:0]       wb_data;

  rv32_hart_decoder u_decoder (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid    (in_valid),
    .in_instr    (in_instr),
    .in_ready    (in_ready),
    .slot_hart   (slot_hart),
    .dec_valid   (dec_valid),
    .dec_ready   (dec_ready),
    .dec_hart    (dec_hart),
    .dec_rs1     (dec_rs1),
    .dec_rs2     (dec_rs2),
    .dec_rd      (dec_rd),
    .dec_op      (dec_op),
    .dec_use_imm (dec_use_imm),
    .dec_imm     (dec_imm),
    .dec_illegal (dec_illegal)
  );

  rv32_barrel_regfiles u_regfiles (
    .clk      (clk),
    .rsa_hart (dec_hart),  // Read bank follows the decoded hart
    .ra1      (dec_rs1),
    .ra2      (dec_rs2),
    .rd1      (rd1),
    .rd2      (rd2),
    .rd_hart  (wb_hart),   // Write bank follows the retiring hart
    .wen      (wb_en),
    .wa       (wb_addr),
    .wd       (wb_data)
  );

  rv32_alu_stage u_alu (
    .clk         (clk),
    .rst_n       (rst_n),
    .dec_valid   (dec_valid),
    .dec_ready   (dec_ready),
    .dec_hart    (dec_hart),
    .dec_op      (dec_op),
    .dec_use_imm (dec_use_imm),
    .dec_imm     (dec_imm),
    .dec_rd      (dec_rd),
    .dec_illegal (dec_illegal),
    .rd1         (rd1),
    .rd2         (rd2),
    .out_valid   (out_valid),
    .out_ready   (out_ready),
    .out_hart    (out_hart),
    .out_rd      (out_rd),
    .out_data    (out_data),
    .out_illegal (out_illegal),
    .wb_en       (wb_en),
    .wb_hart     (wb_hart),
    .wb_addr     (wb_addr),
    .wb_data     (wb_data)
  );

endmodule

/* rv32_hart_decoder.sv */
module rv32_hart_decoder (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             in_valid,
  input  logic [barrel_pkg::xlen-1:0]       in_instr,
  output logic                             in_ready,
  output logic [barrel_pkg::hart_w-1:0]     slot_hart,
  output logic                             dec_valid,
  input  logic                             dec_ready,
  output logic [barrel_pkg::hart_w-1:0]     dec_hart,
  output logic [barrel_pkg::reg_addr_w-1:0] dec_rs1,
  output logic [barrel_pkg::reg_addr_w-1:0] dec_rs2,
  output logic [barrel_pkg::reg_addr_w-1:0] dec_rd,
  output barrel_pkg::alu_op_t               dec_op,
  output logic                             dec_use_imm,
  output logic [barrel_pkg::xlen-1:0]       dec_imm,
  output logic                             dec_illegal
);

  import barrel_pkg::*;

  rv32_instr_u           instr;
  logic                  in_fire;
  alu_op_t               nxt_op;
  logic                  nxt_use_imm;
  logic                  nxt_illegal;
  logic [reg_addr_w-1:0] nxt_rs1;
  logic [reg_addr_w-1:0] nxt_rs2;
  logic [xlen-1:0]       nxt_imm;

  assign instr    = in_instr;
  assign in_ready = !dec_valid || dec_ready;  // Room now or slot drains this edge
  assign in_fire  = in_valid && in_ready;

  always_comb begin
    nxt_op      = alu_add;
    nxt_use_imm = 1'b0;
    nxt_illegal = 1'b0;
    nxt_rs1     = instr.r.rs1;
    nxt_rs2     = instr.r.rs2;
    nxt_imm     = {{(xlen-12){instr.i.imm12[11]}}, instr.i.imm12};

    case (instr.r.opcode)
      opc_op: begin
        case (instr.r.funct3)
          f3_add:  nxt_op = (instr.r.funct7 == funct7_alt) ? alu_sub : alu_add;
          f3_sll:  nxt_op = alu_sll;
          f3_slt:  nxt_op = alu_slt;
          f3_xor:  nxt_op = alu_xor;
          f3_srl:  nxt_op = alu_srl;
          f3_or:   nxt_op = alu_or;
          f3_and:  nxt_op = alu_and;
          default: nxt_illegal = 1'b1;  // SLTU
        endcase
        // Only SUB may use the alternate funct7, SRA is not supported
        if (!((instr.r.funct7 == funct7_base) ||
              (instr.r.funct7 == funct7_alt && instr.r.funct3 == f3_add))) begin
          nxt_illegal = 1'b1;
        end
      end
      opc_op_imm: begin
        nxt_use_imm = 1'b1;
        nxt_rs2     = '0;  // I form has no second register
        case (instr.i.funct3)
          f3_add:  nxt_op = alu_add;
          f3_slt:  nxt_op = alu_slt;
          f3_xor:  nxt_op = alu_xor;
          f3_or:   nxt_op = alu_or;
          f3_and:  nxt_op = alu_and;
          f3_sll:  nxt_op = alu_sll;
          f3_srl:  nxt_op = alu_srl;
          default: nxt_illegal = 1'b1;  // SLTIU
        endcase
        // Shift immediates carry funct7 in the upper bits
        if ((instr.i.funct3 == f3_sll || instr.i.funct3 == f3_srl) &&
            (instr.r.funct7 != funct7_base)) begin
          nxt_illegal = 1'b1;
        end
      end
      default: nxt_illegal = 1'b1;
    endcase

    if (nxt_illegal) begin
      nxt_rs1 = '0;
      nxt_rs2 = '0;
    end
  end

  // Rotation counter and decode slot occupancy
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dec_valid <= 1'b0;
      slot_hart <= '0;
    end else if (in_fire) begin
      dec_valid <= 1'b1;
      if (slot_hart == hart_w'(num_harts - 1)) begin
        slot_hart <= '0;
      end else begin
        slot_hart <= slot_hart + 1'b1;
      end
    end else if (dec_ready) begin
      dec_valid <= 1'b0;
    end
  end

  // Decoded payload
  always_ff @(posedge clk) begin
    if (in_fire) begin
      dec_hart    <= slot_hart;  // Word belongs to the current slot
      dec_rs1     <= nxt_rs1;
      dec_rs2     <= nxt_rs2;
      dec_rd      <= instr.r.rd;
      dec_op      <= nxt_op;
      dec_use_imm <= nxt_use_imm;
      dec_imm     <= nxt_imm;
      dec_illegal <= nxt_illegal;
    end
  end

endmodule

/* rv32_regfile.sv */
module rv32_regfile (
  input  logic                             clk,
  input  logic [barrel_pkg::reg_addr_w-1:0] ra1,
  input  logic [barrel_pkg::reg_addr_w-1:0] ra2,
  output logic [barrel_pkg::xlen-1:0]       rd1,
  output logic [barrel_pkg::xlen-1:0]       rd2,
  input  logic                             wen,
  input  logic [barrel_pkg::reg_addr_w-1:0] wa,
  input  logic [barrel_pkg::xlen-1:0]       wd
);

  import barrel_pkg::*;

  // x1..x31 only, x0 has no storage
  logic [xlen-1:0] regs [1:31];

  logic ra1_zero;
  logic ra2_zero;

  assign ra1_zero = (ra1 == '0);
  assign ra2_zero = (ra2 == '0);

  // Asynchronous read ports
  assign rd1 = ra1_zero ? '0 : regs[ra1];
  assign rd2 = ra2_zero ? '0 : regs[ra2];

  // Single write port, writes to x0 dropped
  always_ff @(posedge clk) begin
    if (wen && (wa != '0)) begin
      regs[wa] <= wd;
    end
  end

endmodule

/* tb_barrel_top.sv */
module tb_barrel_top;

  import barrel_pkg::*;

  typedef struct packed {
    logic [hart_w-1:0]     hart;
    logic [reg_addr_w-1:0] rd;
    logic [xlen-1:0]       data;
    logic                  illegal;
  } exp_t;

  localparam int ready_limit  = 200;  // Cycles allowed for one input transfer
  localparam int drain_limit  = 500;
  localparam int random_count = 300;
  localparam logic [6:0] enc_op     = 7'b0110011;
  localparam logic [6:0] enc_op_imm = 7'b0010011;

  logic                  clk;
  logic                  rst_n;
  logic                  in_valid;
  logic [xlen-1:0]       in_instr;
  logic                  in_ready;
  logic [hart_w-1:0]     slot_hart;
  logic                  out_valid;
  logic                  out_ready;
  logic [hart_w-1:0]     out_hart;
  logic [reg_addr_w-1:0] out_rd;
  logic [xlen-1:0]       out_data;
  logic                  out_illegal;

  integer            seed;
  logic [xlen-1:0]   model_regs [num_harts][32];  // Reference register banks
  exp_t              exp_q [$];
  exp_t              head;
  logic              head_valid;
  logic [hart_w-1:0] exp_slot;
  logic              pop_pending;
  logic              ready_pattern [1024];
  int                ready_idx;
  int                full_cycles;
  int                out_count;
  int                sent_count;

  tb_clock_gen u_clk (.clk(clk));

  rv32_barrel_top u_dut (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid    (in_valid),
    .in_instr    (in_instr),
    .in_ready    (in_ready),
    .slot_hart   (slot_hart),
    .out_valid   (out_valid),
    .out_ready   (out_ready),
    .out_hart    (out_hart),
    .out_rd      (out_rd),
    .out_data    (out_data),
    .out_illegal (out_illegal)
  );

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  task automatic value_error(input string msg);
    stop_run($sformatf("CHECK FAILED at time %0t: %s", $time, msg));
  endtask

  task automatic refresh_head();
    head_valid = (exp_q.size() > 0);
    if (head_valid) begin
      head = exp_q[0];
    end
  endtask

  function automatic logic [31:0] encode(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [6:0] opc);
    return {f7, rs2, rs1, f3, rd, opc};
  endfunction

  // RV32I semantics applied to the model, one entry per accepted word
  task automatic push_expected(input logic [31:0] word);
    logic [6:0]  opc;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [4:0]  rd_f;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    logic        legal;
    exp_t        e;
    opc  = word[6:0];
    rd_f = word[11:7];
    f3   = word[14:12];
    f7   = word[31:25];
    a    = model_regs[exp_slot][word[19:15]];
    if (opc == enc_op) begin
      b     = model_regs[exp_slot][word[24:20]];
      legal = (f3 != 3'b011) && (f7 == 7'h00 || (f7 == 7'h20 && f3 == 3'b000));
    end else begin
      b     = {{20{word[31]}}, word[31:20]};
      legal = (opc == enc_op_imm) && (f3 != 3'b011) &&
              !((f3 == 3'b001 || f3 == 3'b101) && f7 != 7'h00);
    end
    case (f3)
      3'b000:  res = (opc == enc_op && f7 == 7'h20) ? a - b : a + b;
      3'b001:  res = a << b[4:0];
      3'b010:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b100:  res = a ^ b;
      3'b101:  res = a >> b[4:0];
      3'b110:  res = a | b;
      default: res = a & b;
    endcase
    e.hart    = exp_slot;
    e.rd      = rd_f;
    e.illegal = !legal;
    e.data    = legal ? res : 32'd0;
    if (legal && rd_f != 5'd0) begin
      model_regs[exp_slot][rd_f] = res;
    end
    exp_q.push_back(e);
    sent_count++;
    refresh_head();
  endtask

  // Entered and left 2 units after a rising edge
  task automatic send_instr(input logic [31:0] word);
    int   waited;
    logic taken;
    waited   = 0;
    taken    = 1'b0;
    in_valid = 1'b1;
    in_instr = word;
    while (!taken) begin
      #1;
      taken = in_ready;  // Stable until the coming edge
      @(posedge clk);
      #2;
      waited++;
      if (!taken && waited > ready_limit) begin
        stop_run("Timeout: in_ready stayed low, an instruction could not be delivered");
      end
    end
    push_expected(word);
    exp_slot = hart_w'((int'(exp_slot) + 1) % num_harts);
    in_valid = 1'b0;
  endtask

  task automatic make_random(output logic [31:0] word);
    logic [31:0] r;
    logic [31:0] regs;
    logic [2:0]  f3;
    logic [11:0] imm;
    int          kind;
    r    = $random(seed);
    regs = $random(seed);
    kind = int'(r[4:0]) % 20;
    f3   = r[7:5];
    if (kind < 8) begin
      f3  = (f3 == 3'b011) ? 3'b000 : f3;
      imm = (f3 == 3'b001 || f3 == 3'b101) ? {7'h00, r[12:8]} : r[19:8];
      word = encode(imm[11:5], imm[4:0], regs[9:5], f3, regs[4:0], enc_op_imm);
    end else if (kind < 16) begin
      f3   = (f3 == 3'b011) ? 3'b010 : f3;
      word = encode((f3 == 3'b000 && r[8]) ? 7'h20 : 7'h00, regs[14:10], regs[9:5], f3,
                    regs[4:0], enc_op);
    end else if (kind == 16) begin
      word = encode(7'h00, regs[14:10], regs[9:5], 3'b011, regs[4:0],
                    r[8] ? enc_op : enc_op_imm);  // SLTU and SLTIU
    end else if (kind == 17) begin
      word = encode(7'h20, regs[14:10], regs[9:5], 3'b101, regs[4:0],
                    r[8] ? enc_op : enc_op_imm);  // Arithmetic shifts
    end else if (kind == 18) begin
      word = encode(7'h01, regs[14:10], regs[9:5], f3, regs[4:0], enc_op);
    end else begin
      word = {r[31:12], regs[4:0], 7'b0110111};  // LUI is not supported
    end
  endtask

  // out_ready follows a fixed random pattern once reset is released
  always @(posedge clk) begin
    #2;
    if (rst_n) begin
      out_ready = ready_pattern[ready_idx];
      ready_idx = (ready_idx + 1) % 1024;
    end else begin
      out_ready = 1'b0;
    end
  end

  // Retire the checked entry half a cycle after its handshake
  always @(negedge clk) begin
    if (pop_pending) begin
      out_count++;
      if (exp_q.size() > 0) begin
        void'(exp_q.pop_front());
      end
      refresh_head();
    end
    pop_pending = rst_n && out_valid && out_ready;
    if (rst_n && !in_ready) begin
      full_cycles++;
    end
  end

  a_reset_state: assert property (@(posedge clk)
    (!rst_n || $rose(rst_n)) |-> (in_ready && !out_valid && slot_hart == '0))
    else value_error("in_ready, out_valid or slot_hart wrong at reset");

  a_slot: assert property (@(posedge clk) disable iff (!rst_n) slot_hart == exp_slot)
    else value_error($sformatf("slot_hart %0d, expected %0d", $sampled(slot_hart), exp_slot));

  a_result: assert property (@(posedge clk) disable iff (!rst_n)
    (out_valid && out_ready) |-> (head_valid && out_hart == head.hart && out_rd == head.rd &&
                                  out_data == head.data && out_illegal == head.illegal))
    else value_error($sformatf("got hart %0d rd %0d data %h illegal %b, expected %0d %0d %h %b",
                               $sampled(out_hart), $sampled(out_rd), $sampled(out_data),
                               $sampled(out_illegal), head.hart, head.rd, head.data,
                               head.illegal));

  a_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (out_valid && !out_ready) |=> (out_valid && $stable(out_hart) && $stable(out_rd) &&
                                   $stable(out_data) && $stable(out_illegal)))
    else value_error("output changed while it was stalled");

  // Input stalls exactly when both stages are full and the output is blocked
  a_full: assert property (@(posedge clk) disable iff (!rst_n)
    in_ready == !((sent_count - out_count) >= 2 && !out_ready))
    else value_error("in_ready does not follow pipeline occupancy");

  a_writeback: assert property (@(posedge clk) disable iff (!rst_n)
    u_dut.wb_en == (out_valid && out_ready && head_valid && !head.illegal && head.rd != '0))
    else value_error("register write does not match the retiring instruction");

  initial begin
    logic [31:0] word;
    logic [31:0] r;
    int          waited;
    seed        = 32'hafe8e136;
    rst_n       = 1'b1;
    in_valid    = 1'b0;
    in_instr    = '0;
    out_ready   = 1'b0;
    exp_slot    = '0;
    head        = '0;
    head_valid  = 1'b0;
    pop_pending = 1'b0;
    ready_idx   = 0;
    full_cycles = 0;
    out_count   = 0;
    sent_count  = 0;
    for (int h = 0; h < num_harts; h++) begin
      for (int n = 0; n < 32; n++) begin
        model_regs[h][n] = '0;
      end
    end
    for (int i = 0; i < 1024; i++) begin
      r = $random(seed);
      ready_pattern[i] = (r[2:0] < 3'd5);
    end
    #1 rst_n = 1'b0;
    repeat (8) @(posedge clk);
    #2 rst_n = 1'b1;
    @(posedge clk);
    #2;

    // Known value in every register of every hart
    for (int i = 0; i < num_harts * 31; i++) begin
      r = $random(seed);
      send_instr(encode(r[11:5], r[4:0], 5'd0, 3'b000, 5'(i / num_harts + 1), enc_op_imm));
    end

    // Same register, different value per hart, then read back
    for (int h = 0; h < num_harts; h++) begin
      word = 32'(h * 411 - 700);
      send_instr(encode(word[11:5], word[4:0], 5'd0, 3'b000, 5'd5, enc_op_imm));
    end
    for (int h = 0; h < num_harts; h++) begin
      send_instr(encode(7'h00, 5'd0, 5'd5, 3'b000, 5'd6, enc_op));
    end

    // x0 stays zero, illegal words leave x8 alone
    for (int h = 0; h < num_harts; h++) begin
      send_instr(encode(7'h00, 5'd1, 5'd5, 3'b000, 5'd0, enc_op_imm));
      send_instr(encode(7'h00, 5'd0, 5'd0, 3'b000, 5'd7, enc_op));
    end
    for (int h = 0; h < num_harts; h++) begin
      send_instr(encode(7'h01, 5'd3, 5'd5, 3'b000, 5'd8, enc_op));
      send_instr(encode(7'h00, 5'd0, 5'd5, 3'b010, 5'd8, 7'b0000011));
    end
    for (int h = 0; h < num_harts; h++) begin
      send_instr(encode(7'h00, 5'd0, 5'd8, 3'b000, 5'd9, enc_op));
    end

    for (int i = 0; i < random_count; i++) begin
      make_random(word);
      send_instr(word);
      r = $random(seed);
      if (r[1:0] == 2'b00) begin
        @(posedge clk);
        #2;
      end
    end

    waited = 0;
    while (exp_q.size() != 0) begin
      @(posedge clk);
      #2;
      waited++;
      if (waited > drain_limit) begin
        stop_run("Timeout: not every accepted instruction produced an output");
      end
    end
    repeat (4) @(posedge clk);

    if (full_cycles > 0 && out_count == sent_count) begin
      $display("NO ERRORS");
      $finish;
    end else begin
      stop_run($sformatf("End of test: %0d of %0d outputs seen, in_ready low for %0d cycles",
                         out_count, sent_count, full_cycles));
    end
  end

endmodule

/* tb_clock_gen.sv */
module tb_clock_gen (
  output logic clk
);

  localparam int half_period = 20;  // 40 time unit period

  initial begin
    clk = 1'b0;
    forever begin
      #half_period clk = ~clk;
    end
  end

endmodule
